/* logic/wbuf_pkg.sv */
// ############################
// Weight buffer package
// Tile geometry and FSM states
// ############################

package wbuf_pkg;

  // Array geometry
  localparam int unsigned BITW    = 16;
  localparam int unsigned HEIGHT  = 4;
  localparam int unsigned N_ELMS  = 2;  // Pipeline regs per PE plus one
  localparam int unsigned N_COLS  = 4;
  localparam int unsigned ROW_LEN = N_ELMS * N_COLS;
  localparam int unsigned DW      = ROW_LEN * BITW;

  // Counter and field widths
  localparam int unsigned ROW_W = $clog2(HEIGHT + 1);  // Holds 0..HEIGHT
  localparam int unsigned EL_W  = $clog2(N_ELMS);
  localparam int unsigned COL_W = $clog2(N_COLS);
  localparam int unsigned LEN_W = $clog2(ROW_LEN + 1); // Tile width and height

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOAD   = 2'd1,
    STREAM = 2'd2
  } wbuf_state_e;

endpackage : wbuf_pkg

/* logic/wbuf_ctrl_if.sv */
// ############################
// Weight buffer control bundle
// Strobes and counter positions
// ############################

`timescale 1ns/100ps

interface wbuf_ctrl_if;
  import wbuf_pkg::*;

  logic             load;   // Qualified host load
  logic             clear;
  logic             shift;  // Qualified host shift
  logic [ROW_W-1:0] row;
  logic [EL_W-1:0]  el_addr;
  logic [COL_W-1:0] col_addr;
  logic             rows_full;
  logic             pass_end;

  modport fsm (
    output load, clear, shift,
    input  rows_full, pass_end
  );

  modport cnt (
    input  load, clear, shift,
    output row, el_addr, col_addr, rows_full, pass_end
  );

  modport dp (
    input load, clear, shift, row, el_addr, col_addr
  );

endinterface : wbuf_ctrl_if

/* logic/wbuf_scm.sv */
// ############################
// Weight word store
// Row write, per-row element read
// ############################

`timescale 1ns/100ps

module wbuf_scm #(
  parameter int unsigned WORD_SIZE = 16,
  parameter int unsigned ROWS      = 4,
  parameter int unsigned COLS      = 4,
  parameter int unsigned ELMS      = 2
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         clear_i,
  input  logic                                         write_en_i,
  input  logic [$clog2(ROWS)-1:0]                      write_addr_i,
  input  logic [COLS-1:0][ELMS-1:0][WORD_SIZE-1:0]     wdata_i,
  input  logic                                         read_en_i,
  input  logic [$clog2(ELMS)-1:0]                      elms_read_addr_i,
  input  logic [$clog2(COLS)-1:0]                      cols_read_offs_i,
  output logic [ROWS-1:0][WORD_SIZE-1:0]               rdata_o
);

  logic [ROWS-1:0][COLS-1:0][ELMS-1:0][WORD_SIZE-1:0] mem_q;
  logic [ROWS-1:0][WORD_SIZE-1:0]                     rdata_q;

  // Whole row goes in at once
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      mem_q <= '0;
    end else if (write_en_i) begin
      mem_q[write_addr_i] <= wdata_i;
    end
  end

  // Every row picks the same element position on a read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (clear_i) begin
      rdata_q <= '0;
    end else if (read_en_i) begin
      for (int r = 0; r < ROWS; r++) begin
        rdata_q[r] <= mem_q[r][cols_read_offs_i][elms_read_addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule : wbuf_scm

/* logic/wbuf_datapath.sv */
// ############################
// Weight buffer data path
// Tile padding and word store
// ############################

`timescale 1ns/100ps

module wbuf_datapath (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            start_i,
  input  logic [wbuf_pkg::LEN_W-1:0]                      width_i,
  input  logic [wbuf_pkg::LEN_W-1:0]                      height_i,
  input  logic [wbuf_pkg::DW-1:0]                         w_row_i,
  wbuf_ctrl_if.dp                                         ctrl,
  output logic [wbuf_pkg::HEIGHT-1:0][wbuf_pkg::BITW-1:0] w_buffer_o
);
  import wbuf_pkg::*;

  logic [LEN_W-1:0]                         width_q;
  logic [LEN_W-1:0]                         height_q;
  logic                                     row_active;
  logic [N_COLS-1:0][N_ELMS-1:0][BITW-1:0] w_data;

  // Tile size is taken when a new tile starts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      width_q  <= '0;
      height_q <= '0;
    end else if (ctrl.clear && start_i) begin
      width_q  <= width_i;
      height_q <= height_i;
    end
  end

  assign row_active = LEN_W'(ctrl.row) < height_q;

  for (genvar c = 0; c < N_COLS; c++) begin : gen_pad_col
    for (genvar e = 0; e < N_ELMS; e++) begin : gen_pad_el
      localparam int unsigned D = c * N_ELMS + e;  // Element index in the row
      assign w_data[c][e] = (LEN_W'(D) < width_q && row_active) ?
                            w_row_i[D*BITW +: BITW] : '0;
    end
  end

  wbuf_scm #(
    .WORD_SIZE (BITW),
    .ROWS      (HEIGHT),
    .COLS      (N_COLS),
    .ELMS      (N_ELMS)
  ) i_scm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (ctrl.clear),
    .write_en_i       (ctrl.load),
    .write_addr_i     (ctrl.row[$clog2(HEIGHT)-1:0]),
    .wdata_i          (w_data),
    .read_en_i        (ctrl.shift),
    .elms_read_addr_i (ctrl.el_addr),
    .cols_read_offs_i (ctrl.col_addr),
    .rdata_o          (w_buffer_o)
  );

endmodule : wbuf_datapath

/* logic/wbuf_counters.sv */
// ############################
// Weight buffer counters
// Row, element, column section
// ############################

`timescale 1ns/100ps

module wbuf_counters (
  input  logic     clk_i,
  input  logic     rst_ni,
  wbuf_ctrl_if.cnt ctrl
);
  import wbuf_pkg::*;

  logic [ROW_W-1:0] row_q;
  logic [EL_W-1:0]  el_q, el_d;
  logic [COL_W-1:0] col_q, col_d;
  logic             el_last;
  logic             col_last;

  // Counts accepted rows and wraps once the tile is full
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q <= '0;
    end else if (ctrl.clear || row_q == ROW_W'(HEIGHT)) begin
      row_q <= '0;
    end else if (ctrl.load) begin
      row_q <= row_q + ROW_W'(1);
    end
  end

  assign ctrl.rows_full = ctrl.load && (row_q == ROW_W'(HEIGHT - 1));

  assign el_last  = (el_q == EL_W'(N_ELMS - 1));
  assign col_last = (col_q == COL_W'(N_COLS - 1));

  assign el_d  = el_last ? '0 : el_q + EL_W'(1);
  assign col_d = el_last ? (col_last ? '0 : col_q + COL_W'(1)) : col_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (ctrl.clear) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (ctrl.shift) begin
      el_q  <= el_d;
      col_q <= col_d;  // Steps only when the element wraps
    end
  end

  // Last element of the last column section
  assign ctrl.pass_end = el_last && col_last;

  assign ctrl.row      = row_q;
  assign ctrl.el_addr  = el_q;
  assign ctrl.col_addr = col_q;

endmodule : wbuf_counters

/* logic/wbuf_fsm.sv */
// ############################
// Weight buffer sequencer
// Idle, load and stream states
// ############################

`timescale 1ns/100ps

module wbuf_fsm (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     start_i,
  input  logic     load_i,
  input  logic     shift_i,
  wbuf_ctrl_if.fsm ctrl,
  output logic     w_ready_o,
  output logic     streaming_o,
  output logic     done_o
);
  import wbuf_pkg::*;

  wbuf_state_e state_q, state_d;
  logic        start_ok;
  logic        done_q;

  assign start_ok = start_i && (state_q == IDLE);

  // Host strobes only count in their own phase
  assign ctrl.load  = load_i && (state_q == LOAD);
  assign ctrl.shift = shift_i && (state_q == STREAM);
  assign ctrl.clear = clear_i || start_ok;

  always_comb begin
    state_d = state_q;
    if (clear_i) begin
      state_d = IDLE;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (start_i) state_d = LOAD;
        end
        LOAD: begin
          if (ctrl.rows_full) state_d = STREAM;  // Fourth row accepted
        end
        STREAM: begin
          if (ctrl.shift && ctrl.pass_end) state_d = IDLE;
        end
        default: state_d = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // One cycle pulse after the last shift of a pass
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (clear_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= ctrl.shift && ctrl.pass_end;
    end
  end

  assign w_ready_o   = (state_q == LOAD);
  assign streaming_o = (state_q == STREAM);
  assign done_o      = done_q;

endmodule : wbuf_fsm

/* logic/wbuf_top.sv */
// ############################
// Weight buffer top level
// Sequencer, counters, data path
// ############################

`timescale 1ns/100ps

module wbuf_top (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            clear_i,
  input  logic                                            start_i,
  input  logic [wbuf_pkg::LEN_W-1:0]                      width_i,
  input  logic [wbuf_pkg::LEN_W-1:0]                      height_i,
  input  logic                                            load_i,
  input  logic [wbuf_pkg::DW-1:0]                         w_row_i,
  input  logic                                            shift_i,
  output logic                                            w_ready_o,
  output logic                                            streaming_o,
  output logic                                            done_o,
  output logic [wbuf_pkg::HEIGHT-1:0][wbuf_pkg::BITW-1:0] w_buffer_o
);

  wbuf_ctrl_if ctrl_if ();

  wbuf_fsm i_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .start_i     (start_i),
    .load_i      (load_i),
    .shift_i     (shift_i),
    .ctrl        (ctrl_if.fsm),
    .w_ready_o   (w_ready_o),
    .streaming_o (streaming_o),
    .done_o      (done_o)
  );

  wbuf_counters i_counters (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .ctrl   (ctrl_if.cnt)
  );

  // Padding and storage take their read address from the counters
  wbuf_datapath i_datapath (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .width_i    (width_i),
    .height_i   (height_i),
    .w_row_i    (w_row_i),
    .ctrl       (ctrl_if.dp),
    .w_buffer_o (w_buffer_o)
  );

endmodule : wbuf_top

/* testbench/wbuf_asserts.sv */
// ##############################
// Sequencer assertions
// Pulse, phase and stray shift rules
// ##############################

`timescale 1ns/100ps

module wbuf_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  clear_i,
  input logic                  start_i,
  input logic                  load_i,
  input logic                  shift_i,
  input wbuf_pkg::wbuf_state_e state_i,
  input logic                  w_ready_i,
  input logic                  streaming_i,
  input logic                  done_i
);
  import wbuf_pkg::*;

  done_single_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i
  ) else $error("done_o stayed high for more than one cycle");

  // Load and stream phases never overlap
  phase_excl_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(w_ready_i && streaming_i)
  ) else $error("w_ready_o and streaming_o are high together");

  stray_shift_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (shift_i && state_i != STREAM && !clear_i && !start_i && !load_i)
      |=> state_i == $past(state_i)
  ) else $error("a shift outside the stream phase changed the state");

endmodule : wbuf_asserts

bind wbuf_fsm wbuf_asserts i_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .clear_i     (clear_i),
  .start_i     (start_i),
  .load_i      (load_i),
  .shift_i     (shift_i),
  .state_i     (state_q),
  .w_ready_i   (w_ready_o),
  .streaming_i (streaming_o),
  .done_i      (done_o)
);

/* testbench/tb_wbuf_top.sv */
// ##############################
// Weight buffer testbench
// Tile table, padding model, checks
// ##############################

`timescale 1ns/100ps

module tb_wbuf_top;
  import wbuf_pkg::*;

  typedef struct packed {
    logic [LEN_W-1:0] width;
    logic [LEN_W-1:0] height;
    logic             clear_mid;  // Abort the pass halfway
    logic             stray;      // Strobes in the wrong phase
  } tile_entry_t;

  localparam int N_ENTRIES  = 10;
  localparam int MAX_CYCLES = N_ENTRIES * 40 + 100;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        clear_i;
  logic                        start_i;
  logic [LEN_W-1:0]            width_i;
  logic [LEN_W-1:0]            height_i;
  logic                        load_i;
  logic [DW-1:0]               w_row_i;
  logic                        shift_i;
  logic                        w_ready_o;
  logic                        streaming_o;
  logic                        done_o;
  logic [HEIGHT-1:0][BITW-1:0] w_buffer_o;

  tile_entry_t     tiles [N_ENTRIES];
  logic [BITW-1:0] rows_q [HEIGHT][ROW_LEN];  // Unpadded words of the current tile
  int              errors = 0;
  int              checks = 0;
  int              cycles = 0;

  wbuf_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .start_i     (start_i),
    .width_i     (width_i),
    .height_i    (height_i),
    .load_i      (load_i),
    .w_row_i     (w_row_i),
    .shift_i     (shift_i),
    .w_ready_o   (w_ready_o),
    .streaming_o (streaming_o),
    .done_o      (done_o),
    .w_buffer_o  (w_buffer_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic tile_entry_t make_entry(input int w, input int h, input bit c,
                                             input bit s);
    tile_entry_t e;
    e.width     = LEN_W'(w);
    e.height    = LEN_W'(h);
    e.clear_mid = c;
    e.stray     = s;
    return e;
  endfunction

  // Width, height, clear mid pass, stray strobes
  task automatic fill_table();
    tiles[0] = make_entry(8, 4, 1'b0, 1'b0);
    tiles[1] = make_entry(8, 4, 1'b0, 1'b1);
    tiles[2] = make_entry(5, 3, 1'b0, 1'b0);
    tiles[3] = make_entry(3, 1, 1'b0, 1'b1);
    tiles[4] = make_entry(8, 4, 1'b1, 1'b0);
    tiles[5] = make_entry(0, 4, 1'b0, 1'b0);
    tiles[6] = make_entry(7, 2, 1'b0, 1'b1);
    tiles[7] = make_entry(8, 0, 1'b0, 1'b0);
    tiles[8] = make_entry(6, 4, 1'b1, 1'b1);
    tiles[9] = make_entry(8, 4, 1'b0, 1'b0);
  endtask

  task automatic check_value(input string name, input logic [DW-1:0] actual,
                             input logic [DW-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t",
               name, actual, expected, $time);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // Padding rule applied to the stored random words
  function automatic logic [BITW-1:0] padded_word(input int r, input int d,
                                                  input tile_entry_t t);
    if (d < int'(t.width) && r < int'(t.height)) begin
      return rows_q[r][d];
    end
    return '0;
  endfunction

  function automatic logic [DW-1:0] pack_row(input int r);
    logic [DW-1:0] row;
    row = '0;
    for (int d = 0; d < ROW_LEN; d++) begin
      row[d*BITW +: BITW] = rows_q[r][d];
    end
    return row;
  endfunction

  function automatic logic [DW-1:0] random_row();
    logic [DW-1:0] row;
    for (int d = 0; d < ROW_LEN; d++) begin
      row[d*BITW +: BITW] = BITW'($urandom);
    end
    return row;
  endfunction

  task automatic check_flags(input logic ready, input logic streaming, input logic done);
    check_value("w_ready_o", DW'(w_ready_o), DW'(ready));
    check_value("streaming_o", DW'(streaming_o), DW'(streaming));
    check_value("done_o", DW'(done_o), DW'(done));
  endtask

  task automatic check_zero_buffer();
    check_value("w_buffer_o", DW'(w_buffer_o), '0);
  endtask

  // Every row shows element k of its padded tile row
  task automatic check_buffer(input int k, input tile_entry_t t);
    for (int r = 0; r < HEIGHT; r++) begin
      check_value($sformatf("w_buffer_o[%0d]", r), DW'(w_buffer_o[r]),
                  DW'(padded_word(r, k, t)));
    end
  endtask

  task automatic run_tile(input int idx);
    tile_entry_t t;
    logic        aborted;
    t       = tiles[idx];
    aborted = 1'b0;
    for (int r = 0; r < HEIGHT; r++) begin
      for (int d = 0; d < ROW_LEN; d++) begin
        rows_q[r][d] = BITW'($urandom);
      end
    end

    width_i  = t.width;
    height_i = t.height;
    start_i  = 1'b1;
    next_cycle();
    start_i = 1'b0;
    check_flags(1'b1, 1'b0, 1'b0);
    check_zero_buffer();

    for (int r = 0; r < HEIGHT; r++) begin
      if (t.stray) begin
        shift_i = 1'b1;  // Ignored while loading
        next_cycle();
        shift_i = 1'b0;
        check_flags(1'b1, 1'b0, 1'b0);
        check_zero_buffer();
      end
      load_i  = 1'b1;
      w_row_i = pack_row(r);
      next_cycle();
      load_i  = 1'b0;
      w_row_i = random_row();
      check_flags(r != HEIGHT - 1, r == HEIGHT - 1, 1'b0);
      check_zero_buffer();
    end

    for (int k = 0; k < ROW_LEN && !aborted; k++) begin
      shift_i = 1'b1;
      next_cycle();
      shift_i = 1'b0;
      check_buffer(k, t);
      check_flags(1'b0, k != ROW_LEN - 1, k == ROW_LEN - 1);
      if (t.stray) begin
        load_i  = 1'b1;  // Ignored while streaming
        w_row_i = random_row();
      end
      next_cycle();
      load_i = 1'b0;
      check_buffer(k, t);
      check_flags(1'b0, k != ROW_LEN - 1, 1'b0);
      if (t.clear_mid && k == ROW_LEN / 2 - 1) begin
        clear_i = 1'b1;
        next_cycle();
        clear_i = 1'b0;
        check_flags(1'b0, 1'b0, 1'b0);
        check_zero_buffer();
        aborted = 1'b1;
      end
    end
  endtask

  initial begin
    void'($urandom(32'ha7c45736));
    rst_ni   = 1'b0;
    clear_i  = 1'b0;
    start_i  = 1'b0;
    load_i   = 1'b0;
    shift_i  = 1'b0;
    width_i  = '0;
    height_i = '0;
    w_row_i  = '0;
    fill_table();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    check_flags(1'b0, 1'b0, 1'b0);
    check_zero_buffer();

    for (int i = 0; i < N_ENTRIES; i++) begin
      run_tile(i);
    end

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_wbuf_top

/* wbuf_top.f */
logic/wbuf_pkg.sv
logic/wbuf_ctrl_if.sv
logic/wbuf_scm.sv
logic/wbuf_datapath.sv
logic/wbuf_counters.sv
logic/wbuf_fsm.sv
logic/wbuf_top.sv
testbench/wbuf_asserts.sv
testbench/tb_wbuf_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the weight buffer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wbuf_top -f wbuf_top.f -o sim_wbuf

./obj_dir/sim_wbuf 2>&1 | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "Simulation reported errors, see $LOG"
  exit 1
fi
echo "Simulation finished without errors"
